/* filelist.f */
logic/ubaPkg.sv
logic/ubaDecode.sv
logic/ubaRegs.sv
logic/ubaIntr.sv
logic/ubaDevMux.sv
logic/ubaBusMonitor.sv
logic/ubaTop.sv
bench/ubaTb.sv

/* run.sh */
#!/bin/sh
# Build the IO bridge testbench with Verilator and run it, failing on a nonzero exit status
verilator --binary --timing -Wno-fatal --top-module ubaTb -f filelist.f -o ubaSim \
   && ./obj_dir/ubaSim \
   || exit 1

/* bench/ubaTb.sv */
// Directed testbench of the IO bridge, run as top level to exercise registers, devices and PI
`timescale 1ns/1ps
`default_nettype none

module ubaTb
   import ubaPkg::*;
();

   localparam int          devCount   = 4;
   localparam int          nxdTimeout = 8;
   localparam logic [17:0] statAddr   = 18'o763100;    // Base plus 100
   localparam logic [17:0] maintAddr  = 18'o763101;
   localparam logic [17:0] devWinAddr = 18'o772000;    // Outside the bridge window
   // About 30 bus cycles of at most 30 clocks, with margin
   localparam int          cycleLimit = 2000;

   logic                clk;
   logic                rst;
   logic                busReq;
   busAddrT             busAddr;
   word36T              busData;
   logic                busAck;
   word36T              busDataOut;
   logic [7:1]          busIntr;
   logic [devCount-1:0] devAck = '0;
   word36T              devWord [devCount];            // Device read data
   devIntrT             devIntr [devCount];
   logic                devReq;
   busAddrT             devAddr;
   word36T              devDataOut;
   logic                devReset;

   // Device model state
   bit      devEn [devCount];
   int      devDelay [devCount];                        // Cycles from devReq to ack
   int      devCnt [devCount];
   bit      seenReq;                                    // devReq seen during the cycle
   busAddrT seenAddr;
   word36T  seenData;

   logic [31:0] rngState = 32'd19178;
   int          cycleCount = 0;
   logic [2:0]  curPih;                                 // Fields last written to status
   logic [2:0]  curPil;
   logic        curIni;

   ubaTop #(.ubaNum(4'd1), .ubaBase(18'o763000), .devCount(devCount),
            .nxdTimeout(nxdTimeout)) u_ubaTop
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busData    (busData),
      .devAck     (devAck),
      .devDataIn  (devWord),
      .devIntr    (devIntr),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .busIntr    (busIntr),
      .devReq     (devReq),
      .devAddr    (devAddr),
      .devDataOut (devDataOut),
      .devReset   (devReset)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                           // 40 ns period
   end

   //////////////////////////////////////////////////
   // Device model and run limit
   //////////////////////////////////////////////////

   always @(negedge clk)
   begin
      for (int i = 0; i < devCount; i++)
      begin
         if (devReq && devEn[i])
         begin
            devAck[i] <= (devCnt[i] >= devDelay[i]);    // Held until devReq drops
            devCnt[i] = devCnt[i] + 1;
         end
         else
         begin
            devAck[i] <= 1'b0;
            devCnt[i] = 0;
         end
      end
      if (devReq)
      begin
         seenReq  = 1'b1;
         seenAddr = devAddr;
         seenData = devDataOut;
      end
   end

   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
         reportFailure($sformatf("run did not finish within %0d cycles", cycleLimit));
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic checkValue(input string testName, input word36T expected, input word36T actual);
      assert (actual === expected)
      else
         reportFailure($sformatf("error %s: expected %h actual %h", testName, expected, actual));
   endtask

   // 32-bit xorshift
   function automatic logic [31:0] nextRandom();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic word36T randomWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = nextRandom();
      lo = nextRandom();
      return {hi[3:0], lo};
   endfunction

   // Physical IO address word, read or write
   function automatic busAddrT makeAddr(input logic rd, input logic [3:0] dev,
                                        input logic [17:0] ioAddr);
      busAddrT a;
      a        = '0;
      a.read   = rd;
      a.write  = !rd;
      a.phys   = 1'b1;
      a.io     = 1'b1;
      a.dev    = dev;
      a.ioAddr = ioAddr;
      return a;
   endfunction

   // Status layout, low bits up: pil, pih, ini, intLo, intHi, nxd
   function automatic word36T statusWord(input logic nxd, input logic intHi, input logic intLo,
                                         input logic ini, input logic [2:0] pih,
                                         input logic [2:0] pil);
      return {26'd0, nxd, intHi, intLo, ini, pih, pil};
   endfunction

   // One CPU cycle, latency counted in clocks from the sampling edge
   task automatic busCycle(input string testName, input busAddrT addr, input word36T data,
                           input bit expectAck, input int waitLimit,
                           output word36T rdata, output int latency);
      bit gotAck;
      gotAck  = 1'b0;
      latency = 0;
      rdata   = '0;
      seenReq = 1'b0;
      busAddr = addr;
      busData = data;
      busReq  = 1'b1;
      while (!gotAck && latency < waitLimit)
      begin
         @(negedge clk);
         latency++;
         if (busAck)
         begin
            gotAck = 1'b1;
            rdata  = busDataOut;                        // Only valid with busAck
         end
      end
      busReq  = 1'b0;
      busAddr = '0;
      busData = '0;
      if (expectAck)
      begin
         assert (gotAck)
         else
            reportFailure($sformatf("%s: no busAck within %0d cycles", testName, waitLimit));
      end
      else
      begin
         assert (!gotAck)
         else
            reportFailure($sformatf("%s: busAck on a cycle that must be ignored", testName));
      end
      @(negedge clk);
      assert (!busAck)
      else
         reportFailure($sformatf("%s: busAck stayed high for more than one cycle", testName));
      @(negedge clk);                                   // Monitor back in idle
   endtask

   task automatic writeStatus(input string testName, input logic ini, input logic [2:0] pih,
                              input logic [2:0] pil, input logic clearNxd);
      word36T wd;
      word36T rd;
      int     lat;
      wd = randomWord();
      wd = {wd[35:10], clearNxd, wd[8:7], ini, pih, pil};   // Junk in ignored bits
      busCycle(testName, makeAddr(1'b0, 4'd1, statAddr), wd, 1'b1, 20, rd, lat);
      checkValue({testName, " data"}, '0, rd);
      checkValue({testName, " latency"}, 1, lat);
      curIni = ini;
      curPih = pih;
      curPil = pil;
   endtask

   task automatic readStatus(input string testName, input logic nxd, input logic intHi,
                             input logic intLo);
      word36T rd;
      int     lat;
      busCycle(testName, makeAddr(1'b1, 4'd1, statAddr), '0, 1'b1, 20, rd, lat);
      checkValue(testName, statusWord(nxd, intHi, intLo, curIni, curPih, curPil), rd);
      checkValue({testName, " latency"}, 1, lat);
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic testStatus();
      logic [31:0] r;
      r = nextRandom();
      writeStatus("status write", r[6], r[5:3], r[2:0], 1'b0);
      readStatus("status read", 1'b0, 1'b0, 1'b0);
      checkValue("status devReset", curIni, devReset);
      writeStatus("status ini flip", !r[6], curPih, curPil, 1'b0);
      readStatus("status read flip", 1'b0, 1'b0, 1'b0);
      checkValue("status devReset flip", curIni, devReset);
   endtask

   task automatic testDevice();
      busAddrT a;
      word36T  wd;
      word36T  rd;
      int      lat;
      devEn[0]    = 1'b1;                               // Device 1, two wait cycles
      devDelay[0] = 2;
      a  = makeAddr(1'b0, 4'd1, devWinAddr);
      wd = randomWord();
      busCycle("device write", a, wd, 1'b1, 20, rd, lat);
      checkValue("device write data", '0, rd);
      checkValue("device write latency", 4, lat);       // devReq +1, ack +2, busAck +1
      checkValue("device write devReq", 1, seenReq);
      checkValue("device write devAddr", a, seenAddr);
      checkValue("device write devDataOut", wd, seenData);
      devEn[0] = 1'b0;
      devEn[1]    = 1'b1;
      devDelay[1] = 1;
      devWord[1]  = randomWord();
      a = makeAddr(1'b1, 4'd1, devWinAddr + 18'o10);
      busCycle("device read", a, '0, 1'b1, 20, rd, lat);
      checkValue("device read data", devWord[1], rd);
      checkValue("device read latency", 3, lat);
      // Devices 2 and 4 ack in the same cycle, lower index wins
      devDelay[1] = 0;
      devEn[3]    = 1'b1;
      devDelay[3] = 0;
      devWord[3]  = randomWord();
      busCycle("device priority", a, '0, 1'b1, 20, rd, lat);
      checkValue("device priority data", devWord[1], rd);
      devEn[1] = 1'b0;
      devEn[3] = 1'b0;
      checkValue("device devReq idle", 0, devReq);
   endtask

   task automatic testNxd();
      word36T rd;
      int     lat;
      busCycle("nxd read", makeAddr(1'b1, 4'd1, devWinAddr), '0, 1'b1, 30, rd, lat);
      checkValue("nxd data", '0, rd);
      checkValue("nxd latency", nxdTimeout + 2, lat);
      readStatus("nxd status set", 1'b1, 1'b0, 1'b0);
      writeStatus("nxd clear", curIni, curPih, curPil, 1'b1);     // Write one to clear
      readStatus("nxd status clear", 1'b0, 1'b0, 1'b0);
   endtask

   task automatic testInterrupts();
      busAddrT a;
      word36T  rd;
      int      lat;
      writeStatus("intr setup", 1'b0, 3'd5, 3'd2, 1'b0);
      for (int i = 0; i < devCount; i++)
         devWord[i] = randomWord();
      devIntr[2] = 4'b0100;                             // Device 3 at level 6
      devIntr[0] = 4'b0001;                             // Device 1 at level 4
      @(negedge clk);
      @(negedge clk);
      checkValue("intr busIntr", 7'b0010010, busIntr);  // Channels 5 and 2
      readStatus("intr status", 1'b0, 1'b1, 1'b1);
      a    = makeAddr(1'b1, 4'd0, 18'd0);               // WRU ignores dev
      a.wru = 1'b1;
      a.pi  = 3'd5;
      busCycle("intr wru", a, '0, 1'b1, 20, rd, lat);
      checkValue("intr wru word", 36'h0_0008_0000, rd); // Bridge 1 answers on bit 19
      checkValue("intr wru latency", 1, lat);
      a      = makeAddr(1'b1, 4'd1, 18'd0);
      a.vect = 1'b1;
      busCycle("intr vector", a, '0, 1'b1, 20, rd, lat);
      checkValue("intr vector data", devWord[2], rd);   // Level 6 beats level 4
      a     = makeAddr(1'b1, 4'd0, 18'd0);
      a.wru = 1'b1;
      a.pi  = 3'd6;                                     // No channel there
      busCycle("intr wru miss", a, '0, 1'b0, 20, rd, lat);
      devIntr[2] = '0;
      devIntr[0] = '0;
   endtask

   task automatic testLoopback();
      word36T wd;
      word36T rd;
      int     lat;
      busCycle("loop enable", makeAddr(1'b0, 4'd1, maintAddr), 36'd1, 1'b1, 20, rd, lat);
      checkValue("loop enable latency", 1, lat);
      wd = randomWord();
      busCycle("loop write", makeAddr(1'b0, 4'd1, devWinAddr), wd, 1'b1, 20, rd, lat);
      checkValue("loop write latency", 1, lat);
      checkValue("loop write devReq", 0, seenReq);
      busCycle("loop read", makeAddr(1'b1, 4'd1, devWinAddr), '0, 1'b1, 20, rd, lat);
      checkValue("loop read data", wd, rd);
      checkValue("loop read devReq", 0, seenReq);
      // Other bridge number, nobody answers
      busCycle("loop other dev", makeAddr(1'b1, 4'd2, devWinAddr), '0, 1'b0, 20, rd, lat);
      busCycle("loop disable", makeAddr(1'b0, 4'd1, maintAddr), '0, 1'b1, 20, rd, lat);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      rst      = 1'b1;
      busReq   = 1'b0;
      busAddr  = '0;
      busData  = '0;
      seenReq  = 1'b0;
      seenAddr = '0;
      seenData = '0;
      curPih   = '0;
      curPil   = '0;
      curIni   = 1'b0;
      for (int i = 0; i < devCount; i++)
      begin
         devWord[i]  = '0;
         devIntr[i]  = '0;
         devEn[i]    = 1'b0;
         devDelay[i] = 0;
         devCnt[i]   = 0;
      end
      repeat (3) @(negedge clk);                        // Three reset edges
      rst = 1'b0;
      checkValue("reset busAck", 0, busAck);
      checkValue("reset devReq", 0, devReq);
      checkValue("reset busIntr", 0, busIntr);
      checkValue("reset devReset", 0, devReset);
      readStatus("reset status", 1'b0, 1'b0, 1'b0);
      testStatus();
      testDevice();
      testNxd();
      testInterrupts();
      testLoopback();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/ubaTop.sv */
// IO bridge top level, instantiated by the system between the backplane bus and the devices
`timescale 1ns/1ps
`default_nettype none

module ubaTop
   import ubaPkg::*;
#(
   parameter logic [3:0]  ubaNum     = 4'd1,         // Bridge number
   parameter logic [17:0] ubaBase    = 18'o763000,   // Base of the register window
   parameter int          devCount   = 4,
   parameter int          nxdTimeout = 8             // Wait cycles before NXD
)
(
   input  logic                clk,
   input  logic                rst,
   // Backplane side
   input  logic                busReq,               // Held until busAck
   input  busAddrT             busAddr,
   input  word36T              busData,
   output logic                busAck,               // One cycle pulse
   output word36T              busDataOut,
   output logic [7:1]          busIntr,              // PI channels 1 to 7
   // Device side
   input  logic [devCount-1:0] devAck,
   input  word36T              devDataIn [devCount],
   input  devIntrT             devIntr [devCount],
   output logic                devReq,               // Shared by all devices
   output busAddrT             devAddr,
   output word36T              devDataOut,
   output logic                devReset
);

   cycleKindE cycleKind;
   statusRegT status;
   logic      loopEn;
   word36T    loopData;
   logic      intHi;
   logic      intLo;
   logic      wruHit;
   word36T    wruWord;
   word36T    selData;
   logic      devAny;
   logic      ackNow;                                // Register write strobe
   logic      nxdSet;

   // Devices see the CPU address and data as is
   assign devAddr    = busAddr;
   assign devDataOut = busData;

   ubaDecode #(.ubaNum(ubaNum), .ubaBase(ubaBase)) u_ubaDecode
   (
      .busAddr   (busAddr),
      .loopEn    (loopEn),
      .cycleKind (cycleKind)
   );

   ubaRegs u_ubaRegs
   (
      .clk       (clk),
      .rst       (rst),
      .cycleKind (cycleKind),
      .busData   (busData),
      .ackNow    (ackNow),
      .nxdSet    (nxdSet),
      .intHi     (intHi),
      .intLo     (intLo),
      .status    (status),
      .loopEn    (loopEn),
      .loopData  (loopData),
      .devReset  (devReset)
   );

   ubaIntr #(.devCount(devCount), .ubaNum(ubaNum)) u_ubaIntr
   (
      .devIntr   (devIntr),
      .status    (status),
      .busAddr   (busAddr),
      .busIntr   (busIntr),
      .intHi     (intHi),
      .intLo     (intLo),
      .wruHit    (wruHit),
      .wruWord   (wruWord)
   );

   ubaDevMux #(.devCount(devCount)) u_ubaDevMux
   (
      .cycleKind (cycleKind),
      .devAck    (devAck),
      .devDataIn (devDataIn),
      .devIntr   (devIntr),
      .selData   (selData),
      .devAny    (devAny)
   );

   ubaBusMonitor #(.nxdTimeout(nxdTimeout)) u_ubaBusMonitor
   (
      .clk        (clk),
      .rst        (rst),
      .busReq     (busReq),
      .cycleKind  (cycleKind),
      .devAny     (devAny),
      .selData    (selData),
      .status     (status),
      .loopData   (loopData),
      .wruHit     (wruHit),
      .wruWord    (wruWord),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .devReq     (devReq),
      .ackNow     (ackNow),
      .nxdSet     (nxdSet)
   );

endmodule

`default_nettype wire

/* logic/ubaBusMonitor.sv */
// Bus monitor of the IO bridge, acks claimed cycles, registers read data and times out devices
`timescale 1ns/1ps
`default_nettype none

module ubaBusMonitor
   import ubaPkg::*;
#(
   parameter int nxdTimeout = 8                      // Wait cycles before NXD
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      busReq,
   input  cycleKindE cycleKind,
   input  logic      devAny,
   input  word36T    selData,
   input  statusRegT status,
   input  word36T    loopData,
   input  logic      wruHit,
   input  word36T    wruWord,
   output logic      busAck,
   output word36T    busDataOut,                     // Valid with busAck only
   output logic      devReq,
   output logic      ackNow,                         // Edge into monAck
   output logic      nxdSet
);

   localparam int CNT_W = $clog2(nxdTimeout + 1);

   monStateE         state;
   monStateE         stateNext;
   logic [CNT_W-1:0] waitCnt;
   logic             localHit;                       // Answered by the bridge itself
   logic             devCycle;
   logic             timeout;
   word36T           readData;

   //////////////////////////////////////////////////
   // Cycle classes and read data
   //////////////////////////////////////////////////

   always_comb
   begin
      unique case (cycleKind)
         cycleStatRead, cycleStatWrite, cycleMaintWrite,
         cycleLoopRead, cycleLoopWrite, cycleLocalOther,
         cycleVect : localHit = 1'b1;
         cycleWru  : localHit = wruHit;               // Only if a channel matches
         default   : localHit = 1'b0;
      endcase
   end

   assign devCycle = (cycleKind == cycleDevRead) || (cycleKind == cycleDevWrite);

   // Writes return zero
   always_comb
   begin
      unique case (cycleKind)
         cycleStatRead : readData = word36T'(status);
         cycleLoopRead : readData = loopData;
         cycleWru      : readData = wruWord;
         cycleVect,
         cycleDevRead  : readData = selData;
         default       : readData = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////

   // Ack wins over a timeout in the same cycle
   assign timeout = (state == monWait) && !devAny && (waitCnt == CNT_W'(nxdTimeout));

   always_comb
   begin
      stateNext = state;
      unique case (state)
         monIdle :
            if (busReq && localHit)
               stateNext = monAck;
            else if (busReq && devCycle)
               stateNext = monWait;
         monWait :
            if (devAny || timeout)
               stateNext = monAck;
         monAck  : stateNext = monDone;
         monDone :
            if (!busReq)                             // Hold until the CPU lets go
               stateNext = monIdle;
         default : stateNext = monIdle;
      endcase
   end

   assign ackNow = (stateNext == monAck);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state      <= monIdle;
         waitCnt    <= '0;
         nxdSet     <= 1'b0;
         busDataOut <= '0;
      end
      else
      begin
         state  <= stateNext;
         nxdSet <= timeout;                          // Lines up with busAck
         if (state == monWait)
            waitCnt <= waitCnt + 1'b1;
         else
            waitCnt <= '0;
         busDataOut <= (ackNow && !timeout) ? readData : '0;
      end
   end

   assign busAck = (state == monAck);
   assign devReq = (state == monWait);               // Drops when the wait ends

endmodule

`default_nettype wire

/* logic/ubaDevMux.sv */
// Device data selector of the IO bridge, picks the device whose word returns to the CPU
`timescale 1ns/1ps
`default_nettype none

module ubaDevMux
   import ubaPkg::*;
#(
   parameter int devCount = 4
)
(
   input  cycleKindE           cycleKind,
   input  logic [devCount-1:0] devAck,
   input  word36T              devDataIn [devCount],
   input  devIntrT             devIntr [devCount],
   output word36T              selData,
   output logic                devAny                // Some device acks
);

   logic found;

   assign devAny = |devAck;

   always_comb
   begin
      selData = '0;
      found   = 1'b0;
      if (cycleKind == cycleVect)
      begin
         // Level first, then lowest device index
         for (int lvl = 7; lvl >= 4; lvl--)
            for (int i = 0; i < devCount; i++)
               if (!found && devIntr[i][lvl])
               begin
                  selData = devDataIn[i];
                  found   = 1'b1;
               end
      end
      else
      begin
         for (int i = 0; i < devCount; i++)         // Fixed priority on ack
            if (!found && devAck[i])
            begin
               selData = devDataIn[i];
               found   = 1'b1;
            end
      end
   end

endmodule

`default_nettype wire

/* logic/ubaIntr.sv */
// Interrupt merge of the IO bridge, drives the PI request lines and answers WRU cycles
`timescale 1ns/1ps
`default_nettype none

module ubaIntr
   import ubaPkg::*;
#(
   parameter int         devCount = 4,
   parameter logic [3:0] ubaNum   = 4'd1
)
(
   input  devIntrT    devIntr [devCount],
   input  statusRegT  status,
   input  busAddrT    busAddr,
   output logic [7:1] busIntr,                       // PI channels 1 to 7
   output logic       intHi,
   output logic       intLo,
   output logic       wruHit,
   output word36T     wruWord
);

   // One bit per bridge number, above the IO address field
   localparam word36T WRU_WORD = word36T'(1) << (18 + ubaNum);

   devIntrT anyLevel;                                // OR of all devices

   always_comb
   begin
      anyLevel = '0;
      for (int i = 0; i < devCount; i++)
         anyLevel = anyLevel | devIntr[i];
   end

   assign intHi = anyLevel[7] | anyLevel[6];
   assign intLo = anyLevel[5] | anyLevel[4];

   // Channel 0 means not assigned
   always_comb
   begin
      busIntr = '0;
      if (intHi && status.pih != 3'd0)
         busIntr[status.pih] = 1'b1;
      if (intLo && status.pil != 3'd0)
         busIntr[status.pil] = 1'b1;
   end

   assign wruHit = (status.pih != 3'd0 && busAddr.pi == status.pih) ||
                   (status.pil != 3'd0 && busAddr.pi == status.pil);
   assign wruWord = WRU_WORD;

endmodule

`default_nettype wire

/* logic/ubaRegs.sv */
// Status, maintenance and loopback registers of the IO bridge, written when a cycle is acked
`timescale 1ns/1ps
`default_nettype none

module ubaRegs
   import ubaPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  cycleKindE cycleKind,
   input  word36T    busData,
   input  logic      ackNow,                         // Write strobe from the monitor
   input  logic      nxdSet,                         // Device timeout
   input  logic      intHi,
   input  logic      intLo,
   output statusRegT status,
   output logic      loopEn,
   output word36T    loopData,
   output logic      devReset
);

   statusRegT  wrData;                               // CPU data in status layout
   logic [2:0] pih;
   logic [2:0] pil;
   logic       ini;
   logic       nxd;
   logic       statWr;

   assign wrData = statusRegT'(busData);
   assign statWr = ackNow && (cycleKind == cycleStatWrite);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pih      <= '0;
         pil      <= '0;
         ini      <= 1'b0;
         nxd      <= 1'b0;
         loopEn   <= 1'b0;
         loopData <= '0;
      end
      else
      begin
         if (statWr)
         begin
            pih <= wrData.pih;
            pil <= wrData.pil;
            ini <= wrData.ini;
         end
         // Set beats a write-one clear
         if (nxdSet)
            nxd <= 1'b1;
         else if (statWr && wrData.nxd)
            nxd <= 1'b0;
         if (ackNow && cycleKind == cycleMaintWrite)
            loopEn <= busData[0];                    // Loopback enable in bit 0
         if (ackNow && cycleKind == cycleLoopWrite)
            loopData <= busData;
      end
   end

   // Interrupt summary bits are live
   assign status = '{rsvd: '0, nxd: nxd, intHi: intHi, intLo: intLo,
                     ini: ini, pih: pih, pil: pil};

   assign devReset = ini;                            // INI holds the devices in reset

endmodule

`default_nettype wire

/* logic/ubaDecode.sv */
// Address decoder of the IO bridge, turns the backplane address word into one cycle kind
`timescale 1ns/1ps
`default_nettype none

module ubaDecode
   import ubaPkg::*;
#(
   parameter logic [3:0]  ubaNum  = 4'd1,
   parameter logic [17:0] ubaBase = 18'o763000
)
(
   input  busAddrT   busAddr,
   input  logic      loopEn,                         // Maintenance loopback on
   output cycleKindE cycleKind
);

   localparam logic [17:0] STAT_ADDR  = ubaBase + STAT_OFFSET;
   localparam logic [17:0] MAINT_ADDR = ubaBase + MAINT_OFFSET;

   logic claimed;
   logic devMatch;
   logic inWindow;

   // Physical IO with exactly one direction
   assign claimed  = busAddr.io & busAddr.phys & (busAddr.read ^ busAddr.write);
   assign devMatch = (busAddr.dev == ubaNum);
   assign inWindow = (busAddr.ioAddr[17:WINDOW_BITS] == ubaBase[17:WINDOW_BITS]);

   always_comb
   begin
      cycleKind = cycleNone;
      if (!claimed)
         cycleKind = cycleNone;
      else if (busAddr.wru)                          // WRU goes to every bridge
         cycleKind = busAddr.read ? cycleWru : cycleNone;
      else if (!devMatch)
         cycleKind = cycleNone;
      else if (busAddr.vect)
         cycleKind = busAddr.read ? cycleVect : cycleNone;
      else if (inWindow)
      begin
         if (busAddr.ioAddr == STAT_ADDR)
            cycleKind = busAddr.read ? cycleStatRead : cycleStatWrite;
         else if (busAddr.ioAddr == MAINT_ADDR && busAddr.write)
            cycleKind = cycleMaintWrite;             // Write only register
         else
            cycleKind = cycleLocalOther;
      end
      else if (loopEn)                               // Device window diverted
         cycleKind = busAddr.read ? cycleLoopRead : cycleLoopWrite;
      else
         cycleKind = busAddr.read ? cycleDevRead : cycleDevWrite;
   end

endmodule

`default_nettype wire

/* logic/ubaPkg.sv */
// Shared types and constants of the IO bridge, imported by every bridge module
`default_nettype none

package ubaPkg;

   //////////////////////////////////////////////////
   // Backplane words
   //////////////////////////////////////////////////

   typedef logic [35:0] word36T;                     // Data or address word

   // Address word layout, flag bits at the top
   typedef struct packed
   {
      logic        read;                             // Read cycle
      logic        write;                            // Write cycle
      logic        phys;                             // Physical reference
      logic        io;                               // IO cycle
      logic        wru;                              // Who-are-you request
      logic        vect;                             // Interrupt vector read
      logic        ioByte;                           // Byte cycle, not decoded here
      logic [2:0]  pi;                               // PI channel for WRU
      logic [3:0]  spare;
      logic [3:0]  dev;                              // Bridge number
      logic [17:0] ioAddr;                           // IO address
   } busAddrT;

   // Cycle classes seen by the bridge
   typedef enum logic [3:0]
   {
      cycleNone,                                     // Not ours
      cycleWru,
      cycleVect,
      cycleStatRead,
      cycleStatWrite,
      cycleMaintWrite,
      cycleLoopRead,
      cycleLoopWrite,
      cycleDevRead,
      cycleDevWrite,
      cycleLocalOther                                // Window hole, reads as zero
   } cycleKindE;

   //////////////////////////////////////////////////
   // Status register and bus monitor
   //////////////////////////////////////////////////

   typedef struct packed
   {
      logic [25:0] rsvd;                             // Reads as zero
      logic        nxd;                              // Sticky nonexistent device
      logic        intHi;                            // Live high level summary
      logic        intLo;                            // Live low level summary
      logic        ini;                              // Device reset
      logic [2:0]  pih;                              // High PI channel
      logic [2:0]  pil;                              // Low PI channel
   } statusRegT;

   typedef enum logic [1:0] {monIdle, monWait, monAck, monDone} monStateE;

   typedef logic [7:4] devIntrT;                     // One device, levels 7 down to 4

   localparam logic [17:0] STAT_OFFSET  = 18'o100;
   localparam logic [17:0] MAINT_OFFSET = 18'o101;
   localparam int          WINDOW_BITS  = 7;         // Low bits inside the bridge window

endpackage

`default_nettype wire
